//--- build.f
verilog/alu_pkg.sv
verilog/ripple_adder.sv
verilog/array_multiplier.sv
verilog/int_sqrt.sv
verilog/alu.sv
verilog/operand_registers.sv
verilog/alu_datapath.sv
testbench/alu_datapath_properties.sv
testbench/alu_datapath_tb.sv

//--- run.sh
#!/bin/sh
# builds the ALU datapath testbench with Verilator, runs it and looks for the pass message
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --timescale 1ns/1ps -f build.f \
  --top-module alu_datapath_tb || exit 1
out=$(./obj_dir/Valu_datapath_tb +verilator+error+limit+100)
echo "$out"
echo "$out" | grep -q "All tests passed" && exit 0 || exit 1

//--- testbench/alu_datapath_properties.sv
// assertion checker bound into alu_datapath with a reference model of the bus, registers and ALU
`default_nettype none
`timescale 1ns/1ps

module alu_datapath_properties
  import alu_pkg::*;
(
  input logic                  clk,
  input logic                  reset,
  input ctrl_word_t            ctrl,
  input logic [data_width-1:0] data_in,
  input logic [data_width-1:0] bus,
  input alu_flags_t            flags,
  input logic [data_width-1:0] reg_a,
  input logic [data_width-1:0] reg_b,
  input logic [data_width-1:0] alu_result
);

  int error_count = 0; // polled by the testbench

  logic [data_width-1:0]   model_a;
  logic [data_width-1:0]   model_b;
  logic [data_width-1:0]   model_result;
  alu_flags_t              model_flags;
  logic [data_width-1:0]   model_bus;
  logic [data_width-1:0]   exp_result;
  alu_flags_t              exp_flags;
  logic [data_width:0]     wide_sum;
  logic [2*data_width-1:0] prod;
  logic                    op_defined;
  logic                    idle_q;
  logic [data_width-1:0]   held_result;
  alu_flags_t              held_flags;

  assign op_defined = (ctrl.op <= op_mhi);

  always_comb begin
    case (ctrl.bus_src)
      bus_data_in: model_bus = data_in;
      bus_alu:     model_bus = model_result;
      bus_reg_a:   model_bus = model_a;
      default:     model_bus = model_b;
    endcase
  end

  always_comb begin
    exp_result = '0;
    exp_flags  = '0;
    wide_sum   = {1'b0, model_a} + {1'b0, model_b};
    prod       = {{data_width{1'b0}}, model_a} * {{data_width{1'b0}}, model_b};
    if (ctrl.op == op_adc) begin
      wide_sum = wide_sum + {{data_width{1'b0}}, model_flags.carry}; // old carry in
    end
    case (ctrl.op)
      op_add, op_adc: begin
        exp_result      = wide_sum[data_width-1:0];
        exp_flags.carry = wide_sum[data_width];
      end
      op_sub: begin
        exp_result      = model_a - model_b;
        exp_flags.carry = (model_a < model_b); // borrow
      end
      op_inc: begin
        exp_result      = model_a + data_width'(1);
        exp_flags.carry = (model_a == 8'hff);
      end
      op_dec: begin
        exp_result      = model_a - data_width'(1);
        exp_flags.carry = (model_a == 8'h00);
      end
      op_and:  exp_result = model_a & model_b;
      op_or:   exp_result = model_a | model_b;
      op_xor:  exp_result = model_a ^ model_b;
      op_sqrt: begin
        for (int k = 0; k < 16; k++) begin
          if (k * k <= int'(model_a)) begin
            exp_result = data_width'(k); // largest k with k*k <= a
          end
        end
      end
      op_mlo, op_mhi: begin
        exp_result = (ctrl.op == op_mlo) ? prod[data_width-1:0]
                                         : prod[2*data_width-1:data_width];
        exp_flags.carry = (prod[2*data_width-1:data_width] != '0);
      end
      default: exp_result = '0;
    endcase
    exp_flags.zero = (exp_result == '0);
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      model_a      <= '0;
      model_b      <= '0;
      model_result <= '0;
      model_flags  <= '0;
      idle_q       <= 1'b0;
      held_result  <= '0;
      held_flags   <= '0;
    end else begin
      if (ctrl.load_a) begin
        model_a <= model_bus;
      end
      if (ctrl.load_b) begin
        model_b <= model_bus;
      end
      if (ctrl.alu_en && op_defined) begin
        model_result <= exp_result;
        model_flags  <= exp_flags;
      end
      idle_q      <= !ctrl.alu_en || !op_defined;
      held_result <= alu_result;
      held_flags  <= flags;
    end
  end

  reset_clears: assert property (@(posedge clk)
      $past(reset) |-> (flags == '0 && alu_result == '0))
    else begin
      error_count++;
      $error("CHECK FAILED reset_clears: expected 0/00, actual %b/%h",
             $sampled(flags), $sampled(alu_result));
    end

  bus_matches: assert property (@(posedge clk) disable iff (reset) bus == model_bus)
    else begin
      error_count++;
      $error("CHECK FAILED bus_matches: expected %h, actual %h",
             $sampled(model_bus), $sampled(bus));
    end

  regs_match: assert property (@(posedge clk) disable iff (reset)
      {reg_a, reg_b} == {model_a, model_b})
    else begin
      error_count++;
      $error("CHECK FAILED regs_match: expected %h, actual %h",
             $sampled({model_a, model_b}), $sampled({reg_a, reg_b}));
    end

  result_matches: assert property (@(posedge clk) disable iff (reset)
      alu_result == model_result)
    else begin
      error_count++;
      $error("CHECK FAILED result_matches: expected %h, actual %h",
             $sampled(model_result), $sampled(alu_result));
    end

  flags_match: assert property (@(posedge clk) disable iff (reset) flags == model_flags)
    else begin
      error_count++;
      $error("CHECK FAILED flags_match: expected %b, actual %b",
             $sampled(model_flags), $sampled(flags));
    end

  // en low or an undefined code must not touch result or flags
  idle_holds: assert property (@(posedge clk) disable iff (reset)
      idle_q |-> (alu_result == held_result && flags == held_flags))
    else begin
      error_count++;
      $error("CHECK FAILED idle_holds: expected %h/%b, actual %h/%b",
             $sampled(held_result), $sampled(held_flags),
             $sampled(alu_result), $sampled(flags));
    end

endmodule

bind alu_datapath alu_datapath_properties u_props (
  .clk        (clk),
  .reset      (reset),
  .ctrl       (ctrl),
  .data_in    (data_in),
  .bus        (bus),
  .flags      (flags),
  .reg_a      (reg_a),
  .reg_b      (reg_b),
  .alu_result (alu_result)
);

`default_nettype wire

//--- testbench/alu_datapath_tb.sv
// testbench for the ALU datapath that runs operation sequences for the bound checker
`default_nettype none
`timescale 1ns/1ps

module alu_datapath_tb
  import alu_pkg::*;
();

  logic                  clk = 1'b0;
  logic                  reset;
  ctrl_word_t            ctrl;
  logic [data_width-1:0] data_in;
  logic [data_width-1:0] bus;
  alu_flags_t            flags;
  logic [31:0]           lfsr_state = 32'h6d42b55a;
  int                    cycle_count = 0;

  alu_datapath dut0 (
    .clk     (clk),
    .reset   (reset),
    .ctrl    (ctrl),
    .data_in (data_in),
    .bus     (bus),
    .flags   (flags)
  );

  always #50 clk = ~clk;

  task automatic fail_run(input string reason);
    $display("Some tests failed");
    $fatal(1, "%s", reason);
  endtask

  // fibonacci form with taps 32 22 2 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic random_byte(output logic [data_width-1:0] value);
    for (int i = 0; i < data_width; i++) begin
      lfsr_state = lfsr_step(lfsr_state);
      value[i]   = lfsr_state[0];
    end
  endtask

  // control word for one cycle from the falling edge
  task automatic drive(input alu_op_t code, input logic en, input bus_src_t src,
                       input logic la, input logic lb, input logic [data_width-1:0] data);
    @(negedge clk);
    ctrl    = '{op: code, alu_en: en, bus_src: src, load_a: la, load_b: lb};
    data_in = data;
  endtask

  task automatic run_op(input alu_op_t code, input logic [data_width-1:0] a,
                        input logic [data_width-1:0] b);
    drive(op_add, 1'b0, bus_data_in, 1'b1, 1'b0, a);
    drive(op_add, 1'b0, bus_data_in, 1'b0, 1'b1, b);
    drive(code, 1'b1, bus_reg_a, 1'b0, 1'b0, '0);
    drive(code, 1'b0, bus_alu, 1'b0, 1'b0, '0); // result on the bus
  endtask

  task automatic run_random(input alu_op_t code);
    logic [data_width-1:0] a;
    logic [data_width-1:0] b;
    random_byte(a);
    random_byte(b);
    run_op(code, a, b);
  endtask

  // add, write the sum back into A, then run code on it
  task automatic chain_op(input alu_op_t code);
    logic [data_width-1:0] a;
    logic [data_width-1:0] b;
    random_byte(a);
    random_byte(b);
    drive(op_add, 1'b0, bus_data_in, 1'b1, 1'b0, a);
    drive(op_add, 1'b0, bus_data_in, 1'b0, 1'b1, b);
    drive(op_add, 1'b1, bus_reg_a, 1'b0, 1'b0, '0);
    drive(op_add, 1'b0, bus_alu, 1'b1, 1'b0, '0); // write-back
    drive(code, 1'b1, bus_reg_a, 1'b0, 1'b0, '0);
    drive(code, 1'b0, bus_alu, 1'b0, 1'b0, '0);
  endtask

  always @(posedge clk) begin
    cycle_count = cycle_count + 1;
    if (cycle_count >= 3000) begin // about twice the full test length
      fail_run("timeout: the tests did not finish within 3000 cycles");
    end
  end

  always @(negedge clk) begin
    if (dut0.u_props.error_count != 0) begin
      fail_run("an assertion in the bound checker failed");
    end
  end

  initial begin
    logic [data_width-1:0] edge_values [6] = '{8'hff, 8'h00, 8'h01, 8'hfe, 8'h7f, 8'h80};
    logic [data_width-1:0] sqrt_values [8] = '{8'd0, 8'd1, 8'd225, 8'd255,
                                              8'd15, 8'd16, 8'd143, 8'd144};
    reset   = 1'b1;
    ctrl    = '0;
    data_in = '0;
    repeat (8) @(negedge clk);
    reset = 1'b0;

    drive(op_add, 1'b0, bus_reg_a, 1'b0, 1'b0, '0);
    drive(op_add, 1'b0, bus_reg_b, 1'b0, 1'b0, '0);

    for (int i = 0; i < 40; i++) begin
      run_random(op_add);
      run_random(op_adc); // carry left by the add
      run_random(op_sub);
    end

    foreach (edge_values[i]) begin
      run_op(op_inc, edge_values[i], '0);
      run_op(op_dec, edge_values[i], '0);
    end
    repeat (6) begin
      run_random(op_inc);
      run_random(op_dec);
    end

    for (int i = 0; i < 20; i++) begin
      run_random(op_and);
      run_random(op_or);
      run_random(op_xor);
    end
    foreach (sqrt_values[i]) begin
      run_op(op_sqrt, sqrt_values[i], '0);
    end
    repeat (12) run_random(op_sqrt);

    for (int i = 0; i < 20; i++) begin
      run_random(op_mlo);
      run_random(op_mhi);
    end
    run_random(op_or);
    drive(op_xor, 1'b0, bus_alu, 1'b0, 1'b0, '0);
    drive(alu_op_t'(4'd12), 1'b1, bus_alu, 1'b0, 1'b0, '0);
    drive(alu_op_t'(4'd15), 1'b1, bus_alu, 1'b0, 1'b0, '0);

    for (int i = 0; i < 10; i++) begin
      chain_op(op_inc);
      chain_op(op_sub);
    end

    repeat (2) drive(op_add, 1'b0, bus_reg_a, 1'b0, 1'b0, '0);
    if (dut0.u_props.error_count == 0) begin
      $display("All tests passed");
      $finish;
    end else begin
      fail_run("assertion failures were counted at the end of the run");
    end
  end

endmodule

`default_nettype wire

//--- verilog/alu.sv
// 8-bit ALU of the datapath with registered result and zero/carry flags and one cycle latency
`default_nettype none
`timescale 1ns/1ps

module alu
  import alu_pkg::*;
(
  input  logic                  clk,
  input  logic                  reset,
  input  alu_op_t               op,
  input  logic                  en,
  input  logic [data_width-1:0] a,
  input  logic [data_width-1:0] b,
  output logic [data_width-1:0] result,
  output alu_flags_t            flags
);

  // shared adder operands
  logic [data_width-1:0] add_b;
  logic                  add_cin;
  logic                  add_sub;
  logic [data_width-1:0] add_sum;
  logic                  add_cout;

  logic [2*data_width-1:0] product;
  logic [data_width/2-1:0] root;

  logic [data_width-1:0] next_result;
  alu_flags_t            next_flags;
  logic                  op_valid;

  assign add_b   = (op == op_inc || op == op_dec) ? data_width'(1) : b;
  assign add_cin = (op == op_adc) ? flags.carry : 1'b0; // old carry
  assign add_sub = (op == op_sub || op == op_dec);

  ripple_adder u_adder (
    .a        (a),
    .b        (add_b),
    .cin      (add_cin),
    .subtract (add_sub),
    .sum      (add_sum),
    .cout     (add_cout)
  );

  array_multiplier u_mult (
    .a       (a),
    .b       (b),
    .product (product)
  );

  int_sqrt u_sqrt (
    .radicand (a),
    .root     (root)
  );

  always_comb begin
    next_result = result;
    next_flags  = flags;
    op_valid    = 1'b1;

    case (op)
      op_add, op_adc, op_sub, op_inc, op_dec: begin
        next_result      = add_sum;
        next_flags.carry = add_cout; // borrow for sub and dec
      end
      op_and: begin
        next_result      = a & b;
        next_flags.carry = 1'b0;
      end
      op_or: begin
        next_result      = a | b;
        next_flags.carry = 1'b0;
      end
      op_xor: begin
        next_result      = a ^ b;
        next_flags.carry = 1'b0;
      end
      op_sqrt: begin
        next_result      = {{(data_width/2){1'b0}}, root};
        next_flags.carry = 1'b0;
      end
      op_mlo: begin
        next_result      = product[data_width-1:0];
        next_flags.carry = |product[2*data_width-1:data_width];
      end
      op_mhi: begin
        next_result      = product[2*data_width-1:data_width];
        next_flags.carry = |product[2*data_width-1:data_width];
      end
      default: begin
        op_valid = 1'b0; // undefined code holds everything
      end
    endcase

    if (op_valid) begin
      next_flags.zero = (next_result == '0);
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      result <= '0;
      flags  <= '0;
    end else if (en && op_valid) begin
      result <= next_result;
      flags  <= next_flags;
    end
  end

endmodule

`default_nettype wire

//--- verilog/alu_datapath.sv
// top level of the ALU datapath with the bus source mux, operand registers and ALU
`default_nettype none
`timescale 1ns/1ps

module alu_datapath
  import alu_pkg::*;
(
  input  logic                  clk,
  input  logic                  reset,
  input  ctrl_word_t            ctrl,
  input  logic [data_width-1:0] data_in,
  output logic [data_width-1:0] bus,
  output alu_flags_t            flags
);

  alu_op_t  op;
  logic     alu_en;
  bus_src_t bus_src;
  logic     load_a;
  logic     load_b;

  logic [data_width-1:0] reg_a;
  logic [data_width-1:0] reg_b;
  logic [data_width-1:0] alu_result;

  assign op      = ctrl.op;
  assign alu_en  = ctrl.alu_en;
  assign bus_src = ctrl.bus_src;
  assign load_a  = ctrl.load_a;
  assign load_b  = ctrl.load_b;

  // internal bus source mux
  always_comb begin
    case (bus_src)
      bus_data_in: bus = data_in;
      bus_alu:     bus = alu_result; // write-back path
      bus_reg_a:   bus = reg_a;
      default:     bus = reg_b;
    endcase
  end

  operand_registers u_operand_registers (
    .clk    (clk),
    .reset  (reset),
    .bus    (bus),
    .load_a (load_a),
    .load_b (load_b),
    .reg_a  (reg_a),
    .reg_b  (reg_b)
  );

  alu u_alu (
    .clk    (clk),
    .reset  (reset),
    .op     (op),
    .en     (alu_en),
    .a      (reg_a),
    .b      (reg_b),
    .result (alu_result),
    .flags  (flags)
  );

endmodule

`default_nettype wire

//--- verilog/alu_pkg.sv
// shared types for the 8-bit ALU datapath that every RTL module imports
`default_nettype none

package alu_pkg;

  localparam int data_width = 8; // bus, register and result width

  // codes 11 to 15 are undefined and hold the ALU state
  typedef enum logic [3:0] {
    op_add  = 4'd0,
    op_adc  = 4'd1,
    op_sub  = 4'd2,
    op_inc  = 4'd3,
    op_dec  = 4'd4,
    op_and  = 4'd5,
    op_or   = 4'd6,
    op_xor  = 4'd7,
    op_sqrt = 4'd8,
    op_mlo  = 4'd9,
    op_mhi  = 4'd10
  } alu_op_t;

  // who drives the internal bus
  typedef enum logic [1:0] {
    bus_data_in = 2'd0,
    bus_alu     = 2'd1,
    bus_reg_a   = 2'd2,
    bus_reg_b   = 2'd3
  } bus_src_t;

  // control word applied as a level every cycle
  typedef struct packed {
    alu_op_t  op;
    logic     alu_en;
    bus_src_t bus_src;
    logic     load_a;
    logic     load_b;
  } ctrl_word_t;

  typedef struct packed {
    logic zero;
    logic carry; // carry out or borrow after sub and dec
  } alu_flags_t;

endpackage

`default_nettype wire

//--- verilog/array_multiplier.sv
// unsigned 8x8 array multiplier that feeds the mlo and mhi operations of the ALU
`default_nettype none
`timescale 1ns/1ps

module array_multiplier
  import alu_pkg::*;
(
  input  logic [data_width-1:0]   a,
  input  logic [data_width-1:0]   b,
  output logic [2*data_width-1:0] product
);

  logic [data_width-1:0]   rows [data_width];
  logic [2*data_width-1:0] acc  [data_width + 1];

  assign acc[0] = '0;

  genvar i;
  generate
    for (i = 0; i < data_width; i++) begin : g_row
      // partial product row for multiplier bit i
      assign rows[i] = a & {data_width{b[i]}};

      // add the row in at its weight
      assign acc[i + 1] = acc[i] + ({{data_width{1'b0}}, rows[i]} << i);
    end
  endgenerate

  assign product = acc[data_width];

endmodule

`default_nettype wire

//--- verilog/int_sqrt.sv
// combinational floor square root of an 8-bit value for the sqrt operation of the ALU
`default_nettype none
`timescale 1ns/1ps

module int_sqrt
  import alu_pkg::*;
(
  input  logic [data_width-1:0]   radicand,
  output logic [data_width/2-1:0] root
);

  // restoring method with one root bit per pair of radicand bits
  logic [data_width-1:0]   rem   [data_width/2 + 1];
  logic [data_width/2-1:0] part  [data_width/2 + 1];
  logic [data_width-1:0]   cand  [data_width/2];
  logic [data_width-1:0]   trial [data_width/2];
  logic [data_width:0]     diff  [data_width/2];

  assign rem[0]  = '0;
  assign part[0] = '0;

  genvar s;
  generate
    for (s = 0; s < data_width/2; s++) begin : g_stage
      // bring down the next two radicand bits
      assign cand[s]  = {rem[s][data_width-3:0],
                         radicand[data_width-1-2*s -: 2]};
      assign trial[s] = {part[s], 2'b01};

      // msb set when the trial subtraction does not fit
      assign diff[s] = {1'b0, cand[s]} - {1'b0, trial[s]};

      assign rem[s + 1]  = diff[s][data_width] ? cand[s] : diff[s][data_width-1:0];
      assign part[s + 1] = {part[s][data_width/2-2:0], ~diff[s][data_width]};
    end
  endgenerate

  assign root = part[data_width/2];

endmodule

`default_nettype wire

//--- verilog/operand_registers.sv
// A and B operand registers that the ALU datapath loads from the internal bus
`default_nettype none
`timescale 1ns/1ps

module operand_registers
  import alu_pkg::*;
(
  input  logic                  clk,
  input  logic                  reset,
  input  logic [data_width-1:0] bus,
  input  logic                  load_a,
  input  logic                  load_b,
  output logic [data_width-1:0] reg_a,
  output logic [data_width-1:0] reg_b
);

  always_ff @(posedge clk) begin
    if (reset) begin
      reg_a <= '0;
    end else if (load_a) begin
      reg_a <= bus;
    end
  end

  // may load together with A
  always_ff @(posedge clk) begin
    if (reset) begin
      reg_b <= '0;
    end else if (load_b) begin
      reg_b <= bus;
    end
  end

endmodule

`default_nettype wire

//--- verilog/ripple_adder.sv
// ripple carry adder/subtractor shared by the add, sub, inc and dec operations of the ALU
`default_nettype none
`timescale 1ns/1ps

module ripple_adder
  import alu_pkg::*;
(
  input  logic [data_width-1:0] a,
  input  logic [data_width-1:0] b,
  input  logic                  cin,
  input  logic                  subtract,
  output logic [data_width-1:0] sum,
  output logic                  cout
);

  logic [data_width-1:0] b_in;
  logic [data_width:0]   carry;

  // subtract inverts b and forces the carry in high
  assign b_in     = subtract ? ~b : b;
  assign carry[0] = subtract | cin;

  genvar i;
  generate
    for (i = 0; i < data_width; i++) begin : g_bit
      assign sum[i]       = a[i] ^ b_in[i] ^ carry[i];
      assign carry[i + 1] = (a[i] & b_in[i]) |
                            (a[i] & carry[i]) |
                            (b_in[i] & carry[i]);
    end
  endgenerate

  // borrow is the inverted carry when subtracting
  assign cout = subtract ? ~carry[data_width] : carry[data_width];

endmodule

`default_nettype wire
